/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary -sv -f uart_manage.f --top-module tb_uart_manage -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_uart_manage" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$log_file"; then
    echo "pass message found in $log_file"
    exit 0
fi

echo "pass message not found in $log_file"
exit 1

/* tests/tb_uart_manage.sv */
module tb_uart_manage
    import uart_pkg::*;
();

    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_ROWS        = 19;
    localparam int ROW_LIMIT       = 4 * 200;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 * 200;
    // 16 clocks per bit with CLK_FREQ 16 and BAUD 1
    localparam int IDLE_CYCLES     = 12 * 16;
    localparam int DRAIN_LIMIT     = 2 * ROW_LIMIT;
    localparam logic [31:0] LFSR_SEED = 32'h238a_f7df;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk;
    logic        i_rst;
    logic        i_order;
    xfer_size_t  i_size;
    logic        i_write;
    logic [31:0] i_write_data;
    logic        o_accepted;
    logic        o_done;
    logic [31:0] o_read_data;
    logic        o_txd;
    logic        o_rx_overrun;

    logic        tbl_write   [NUM_ROWS];
    xfer_size_t  tbl_size    [NUM_ROWS];
    logic [31:0] tbl_data    [NUM_ROWS];
    logic [31:0] tbl_expect  [NUM_ROWS];
    logic        tbl_overrun [NUM_ROWS];
    int          row_count;
    int          error_count;
    int          overrun_count;
    logic [31:0] lfsr_state;

    // serial loopback, txd feeds rxd
    uart_manage #(
        .CLK_FREQ(16), .BAUD(1), .FIFO_DEPTH(4), .FIFO_AW(2)
    ) u_uart_manage (
        .i_order(i_order), .i_size(i_size), .i_write(i_write),
        .i_write_data(i_write_data), .i_rxd(o_txd), .clk(clk), .i_rst(i_rst),
        .o_accepted(o_accepted), .o_done(o_done), .o_read_data(o_read_data),
        .o_txd(o_txd), .o_rx_overrun(o_rx_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        if (i_rst) begin
            overrun_count <= 0;
        end else if (o_rx_overrun) begin
            overrun_count <= overrun_count + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            value[i] = lsb;
        end
        return value;
    endfunction

    task automatic add_row(input logic wr, input xfer_size_t size, input logic [31:0] data,
                           input logic [31:0] exp_data, input logic ovr);
        tbl_write[row_count]   = wr;
        tbl_size[row_count]    = size;
        tbl_data[row_count]    = data;
        tbl_expect[row_count]  = exp_data;
        tbl_overrun[row_count] = ovr;
        row_count++;
    endtask

    task automatic build_table();
        logic [31:0] w0;
        logic [31:0] h1;
        logic [31:0] h2;
        row_count = 0;
        w0 = rand_bits(32);
        add_row(1'b1, SIZE_WORD, w0, 32'h0, 1'b0);
        add_row(1'b0, SIZE_WORD, 32'h0, w0, 1'b0);
        add_row(1'b1, SIZE_HALF, 32'h0000_8a3c, 32'h0, 1'b0);
        add_row(1'b0, SIZE_HALF, 32'h0, 32'hffff_8a3c, 1'b0);
        // bit 15 clear, upper half reads back as zero
        h1 = rand_bits(15);
        add_row(1'b1, SIZE_HALF, h1, 32'h0, 1'b0);
        add_row(1'b0, SIZE_HALF, 32'h0, {16'h0000, h1[15:0]}, 1'b0);
        add_row(1'b1, SIZE_BYTE, 32'h0000_00f0, 32'h0, 1'b0);
        add_row(1'b0, SIZE_BYTE, 32'h0, 32'hffff_fff0, 1'b0);
        add_row(1'b1, SIZE_BYTE, 32'h0000_007f, 32'h0, 1'b0);
        add_row(1'b0, SIZE_BYTE, 32'h0, 32'h0000_007f, 1'b0);
        // eight bytes back to back through the 4-deep TX FIFO, which is
        // as much as the 4-deep RX FIFO absorbs before the reads start
        w0 = rand_bits(32);
        h1 = rand_bits(15);
        h2 = rand_bits(15);
        // one positive and one negative halfword
        h2[15] = 1'b1;
        add_row(1'b1, SIZE_WORD, w0, 32'h0, 1'b0);
        add_row(1'b1, SIZE_HALF, h1, 32'h0, 1'b0);
        add_row(1'b1, SIZE_HALF, h2, 32'h0, 1'b0);
        add_row(1'b0, SIZE_WORD, 32'h0, w0, 1'b0);
        add_row(1'b0, SIZE_HALF, 32'h0, {16'h0000, h1[15:0]}, 1'b0);
        add_row(1'b0, SIZE_HALF, 32'h0, {16'hffff, h2[15:0]}, 1'b0);
        // second word lands on a full RX FIFO and is dropped
        w0 = rand_bits(32);
        h1 = rand_bits(32);
        add_row(1'b1, SIZE_WORD, w0, 32'h0, 1'b0);
        add_row(1'b1, SIZE_WORD, h1, 32'h0, 1'b1);
        add_row(1'b0, SIZE_WORD, 32'h0, w0, 1'b0);
    endtask

    task automatic check_idle_outputs(input string phase);
        if (o_txd !== 1'b1) begin
            $display("[ERROR] %s o_txd: expected %h, got %h", phase, 1'b1, o_txd);
            error_count++;
        end
        if (o_done !== 1'b0) begin
            $display("[ERROR] %s o_done: expected %h, got %h", phase, 1'b0, o_done);
            error_count++;
        end
        if (o_rx_overrun !== 1'b0) begin
            $display("[ERROR] %s o_rx_overrun: expected %h, got %h", phase, 1'b0, o_rx_overrun);
            error_count++;
        end
    endtask

    // line counts as idle after 12 bit times high
    task automatic wait_line_idle();
        int high_run;
        int cycles;
        high_run = 0;
        cycles   = 0;
        while (high_run < IDLE_CYCLES && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (o_txd) begin
                high_run++;
            end else begin
                high_run = 0;
            end
        end
        if (high_run < IDLE_CYCLES) begin
            $display("serial line still busy after %0d cycles", DRAIN_LIMIT);
            error_count++;
        end
    endtask

    task automatic apply_row(input int r);
        int   cycles;
        int   ovr_start;
        logic accepted;
        logic done;
        ovr_start = overrun_count;
        @(negedge clk);
        i_order      = 1'b1;
        i_write      = tbl_write[r];
        i_size       = tbl_size[r];
        i_write_data = tbl_data[r];
        accepted     = 1'b0;
        cycles       = 0;
        while (!accepted && cycles < ROW_LIMIT) begin
            #1;
            if (o_accepted) begin
                accepted = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        // order taken at the rising edge in between
        @(negedge clk);
        i_order = 1'b0;
        if (!accepted) begin
            $display("row %0d: order was not accepted within %0d cycles", r, ROW_LIMIT);
            error_count++;
            return;
        end
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < ROW_LIMIT) begin
            if (o_done) begin
                done = 1'b1;
                if (!tbl_write[r] && o_read_data !== tbl_expect[r]) begin
                    $display("[ERROR] row %0d o_read_data: expected %h, got %h",
                             r, tbl_expect[r], o_read_data);
                    error_count++;
                end
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!done) begin
            $display("row %0d: o_done did not arrive within %0d cycles", r, ROW_LIMIT);
            error_count++;
        end
        if (tbl_overrun[r]) begin
            wait_line_idle();
            if (overrun_count == ovr_start) begin
                $display("row %0d: o_rx_overrun never pulsed while the RX FIFO was full", r);
                error_count++;
            end
        end else if (overrun_count != ovr_start) begin
            $display("[ERROR] row %0d o_rx_overrun pulses: expected %h, got %h",
                     r, 0, overrun_count - ovr_start);
            error_count++;
        end
    endtask

    initial begin
        i_rst        = 1'b1;
        i_order      = 1'b0;
        i_size       = SIZE_BYTE;
        i_write      = 1'b0;
        i_write_data = 32'h0;
        error_count  = 0;
        lfsr_state   = LFSR_SEED;
        build_table();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs("reset");
        end
        i_rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end
        $display("rows: %0d, errors: %0d, overrun pulses: %0d",
                 row_count, error_count, overrun_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* uart_manage.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/byte_fifo.sv
verilog/uart_word_ctrl.sv
verilog/uart_manage.sv
tests/tb_uart_manage.sv

/* verilog/byte_fifo.sv */
`include "uart_params.svh"

module byte_fifo #(
    parameter int unsigned DEPTH = `UART_FIFO_DEPTH,
    parameter int unsigned AW    = `UART_FIFO_AW
) (
    input  logic       i_push,
    input  logic [7:0] i_push_data,
    input  logic       i_pop,
    input  logic       clk,
    input  logic       i_rst,
    output logic       o_push_done,
    output logic       o_pop_done,
    output logic [7:0] o_pop_data,
    output logic       o_drop
);

    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          empty;
    logic          push_ok;
    logic          pop_ok;

    // wraps for depths that are not a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == FULL_CNT);
    assign empty   = (count == '0);
    assign push_ok = i_push && !full;
    assign pop_ok  = i_pop && !empty;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    assign o_push_done = push_ok;
    assign o_pop_done  = pop_ok;
    assign o_pop_data  = mem[rd_ptr];
    // push into a full buffer is lost
    assign o_drop      = i_push && full;

endmodule

/* verilog/uart_manage.sv */
`include "uart_params.svh"

module uart_manage
    import uart_pkg::*;
#(
    parameter int unsigned CLK_FREQ   = `UART_CLK_FREQ,
    parameter int unsigned BAUD       = `UART_BAUD,
    parameter int unsigned FIFO_DEPTH = `UART_FIFO_DEPTH,
    parameter int unsigned FIFO_AW    = `UART_FIFO_AW
) (
    input  logic        i_order,
    input  xfer_size_t  i_size,
    input  logic        i_write,
    input  logic [31:0] i_write_data,
    input  logic        i_rxd,
    input  logic        clk,
    input  logic        i_rst,
    output logic        o_accepted,
    output logic        o_done,
    output logic [31:0] o_read_data,
    output logic        o_txd,
    output logic        o_rx_overrun
);

    logic       rx_strobe;
    logic [7:0] rx_byte;
    logic       pop_req;
    logic       pop_done;
    logic [7:0] pop_byte;
    logic       push_req;
    logic [7:0] push_byte;
    logic       push_done;
    logic       tx_ready;
    logic       tx_start;
    logic [7:0] tx_byte;

    uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD(BAUD)) u_rx (
        .i_rxd(i_rxd), .clk(clk), .i_rst(i_rst),
        .o_strobe(rx_strobe), .o_data(rx_byte)
    );

    // receive side, a full buffer drops and flags overrun
    byte_fifo #(.DEPTH(FIFO_DEPTH), .AW(FIFO_AW)) u_rx_fifo (
        .i_push(rx_strobe), .i_push_data(rx_byte), .i_pop(pop_req),
        .clk(clk), .i_rst(i_rst),
        .o_push_done(), .o_pop_done(pop_done), .o_pop_data(pop_byte),
        .o_drop(o_rx_overrun)
    );

    uart_word_ctrl u_ctrl (
        .i_order(i_order), .i_size(i_size), .i_write(i_write),
        .i_write_data(i_write_data),
        .i_pop_done(pop_done), .i_pop_byte(pop_byte), .i_push_done(push_done),
        .clk(clk), .i_rst(i_rst),
        .o_accepted(o_accepted), .o_done(o_done), .o_read_data(o_read_data),
        .o_pop_req(pop_req), .o_push_req(push_req), .o_push_byte(push_byte)
    );

    // transmit side, drained one byte per idle transmitter
    byte_fifo #(.DEPTH(FIFO_DEPTH), .AW(FIFO_AW)) u_tx_fifo (
        .i_push(push_req), .i_push_data(push_byte), .i_pop(tx_ready),
        .clk(clk), .i_rst(i_rst),
        .o_push_done(push_done), .o_pop_done(tx_start), .o_pop_data(tx_byte),
        .o_drop()
    );

    uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD(BAUD)) u_tx (
        .i_start(tx_start), .i_data(tx_byte), .clk(clk), .i_rst(i_rst),
        .o_ready(tx_ready), .o_txd(o_txd)
    );

endmodule

/* verilog/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// system clock in Hz
`define UART_CLK_FREQ 32'd50_000_000

// line rate in bits per second
`define UART_BAUD 32'd115_200

// bytes held by each FIFO
`define UART_FIFO_DEPTH 16

// FIFO pointer width, log2 of the depth
`define UART_FIFO_AW 4

`endif

/* verilog/uart_pkg.sv */
package uart_pkg;

    // bytes moved by one order: 1, 2 or 4
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } xfer_size_t;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

endpackage

/* verilog/uart_rx.sv */
`include "uart_params.svh"

module uart_rx
    import uart_pkg::*;
#(
    parameter int unsigned CLK_FREQ = `UART_CLK_FREQ,
    parameter int unsigned BAUD     = `UART_BAUD
) (
    input  logic       i_rxd,
    input  logic       clk,
    input  logic       i_rst,
    output logic       o_strobe,
    output logic [7:0] o_data
);

    localparam int unsigned CPB = CLK_FREQ / BAUD;
    localparam int unsigned CW  = $clog2(CPB) + 1;

    rx_state_t   state;
    logic        rxd_meta;
    logic        rxd_sync;
    logic        rxd_prev;
    logic [CW-1:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;

    // two-flop synchronizer plus one for edge detect
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            o_strobe <= 1'b0;
        end else begin
            o_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // falling edge starts a frame, wait half a bit
                    if (rxd_prev && !rxd_sync) begin
                        state <= RX_START;
                        cnt   <= CW'(CPB / 2 - 1);
                    end
                end
                RX_START: begin
                    if (cnt == '0) begin
                        // glitch check at mid start bit
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                        cnt     <= CW'(CPB - 1);
                        bit_idx <= '0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == '0) begin
                        cnt     <= CW'(CPB - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == '0) begin
                        // framing error drops the byte
                        o_strobe <= rxd_sync;
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == '0) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

    assign o_data = shreg;

endmodule

/* verilog/uart_tx.sv */
`include "uart_params.svh"

module uart_tx
    import uart_pkg::*;
#(
    parameter int unsigned CLK_FREQ = `UART_CLK_FREQ,
    parameter int unsigned BAUD     = `UART_BAUD
) (
    input  logic       i_start,
    input  logic [7:0] i_data,
    input  logic       clk,
    input  logic       i_rst,
    output logic       o_ready,
    output logic       o_txd
);

    localparam int unsigned CPB = CLK_FREQ / BAUD;
    localparam int unsigned CW  = $clog2(CPB) + 1;

    tx_state_t     state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (i_start) begin
                        state <= TX_START;
                        cnt   <= CW'(CPB - 1);
                        o_txd <= 1'b0;
                    end
                end
                TX_START: begin
                    if (cnt == '0) begin
                        state   <= TX_DATA;
                        cnt     <= CW'(CPB - 1);
                        bit_idx <= '0;
                        o_txd   <= shreg[0];
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                TX_DATA: begin
                    if (cnt == '0) begin
                        cnt     <= CW'(CPB - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            o_txd <= 1'b1;
                        end else begin
                            o_txd <= shreg[1];
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                TX_STOP: begin
                    if (cnt == '0) begin
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // shift on each data bit boundary
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && i_start) begin
            shreg <= i_data;
        end else if (state == TX_DATA && cnt == '0) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    assign o_ready = (state == TX_IDLE);

endmodule

/* verilog/uart_word_ctrl.sv */
module uart_word_ctrl
    import uart_pkg::*;
(
    input  logic        i_order,
    input  xfer_size_t  i_size,
    input  logic        i_write,
    input  logic [31:0] i_write_data,
    input  logic        i_pop_done,
    input  logic [7:0]  i_pop_byte,
    input  logic        i_push_done,
    input  logic        clk,
    input  logic        i_rst,
    output logic        o_accepted,
    output logic        o_done,
    output logic [31:0] o_read_data,
    output logic        o_pop_req,
    output logic        o_push_req,
    output logic [7:0]  o_push_byte
);

    logic        busy;
    logic        wr_q;
    xfer_size_t  size_q;
    logic [2:0]  remain;
    logic [2:0]  size_bytes;
    logic [31:0] wr_aligned;
    logic [31:0] wr_shift;
    logic [31:0] rd_shift;
    logic [31:0] rd_next;
    logic [31:0] rd_ext;
    logic [31:0] read_q;
    logic        ack;
    logic        last;

    assign o_accepted = !busy && i_order;

    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                size_bytes = 3'd1;
                wr_aligned = {i_write_data[7:0], 24'h000000};
            end
            SIZE_HALF: begin
                size_bytes = 3'd2;
                wr_aligned = {i_write_data[15:0], 16'h0000};
            end
            default: begin
                size_bytes = 3'd4;
                wr_aligned = i_write_data;
            end
        endcase
    end

    // one acknowledge per byte, from whichever FIFO is in use
    assign ack  = busy && (wr_q ? i_push_done : i_pop_done);
    assign last = ack && (remain == 3'd1);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            busy   <= 1'b0;
            wr_q   <= 1'b0;
            size_q <= SIZE_BYTE;
            remain <= '0;
        end else if (o_accepted) begin
            busy   <= 1'b1;
            wr_q   <= i_write;
            size_q <= i_size;
            remain <= size_bytes;
        end else if (ack) begin
            remain <= remain - 1'b1;
            if (last) begin
                busy <= 1'b0;
            end
        end
    end

    // msb first in both directions
    assign rd_next = {rd_shift[23:0], i_pop_byte};

    always_comb begin
        case (size_q)
            SIZE_BYTE: rd_ext = {{24{rd_next[7]}}, rd_next[7:0]};
            SIZE_HALF: rd_ext = {{16{rd_next[15]}}, rd_next[15:0]};
            default:   rd_ext = rd_next;
        endcase
    end

    always_ff @(posedge clk) begin
        if (o_accepted) begin
            wr_shift <= wr_aligned;
        end else if (busy && i_push_done) begin
            wr_shift <= {wr_shift[23:0], 8'h00};
        end
        if (busy && i_pop_done) begin
            rd_shift <= rd_next;
        end
        if (last && !wr_q) begin
            read_q <= rd_ext;
        end
    end

    assign o_done      = last;
    // result shows in the completing cycle, then is held
    assign o_read_data = (last && !wr_q) ? rd_ext : read_q;
    assign o_pop_req   = busy && !wr_q;
    assign o_push_req  = busy && wr_q;
    assign o_push_byte = wr_shift[31:24];

endmodule
